//--- ldq.f
+incdir+verilog
verilog/ldq_pkg.sv
verilog/ldq_alloc.sv
verilog/ldq_entry_array.sv
verilog/ldq_age_pick.sv
verilog/ldq_fire.sv
verilog/ldq_writeback.sv
verilog/ldq.sv
testbench/ldq_tb_clk.sv
testbench/ldq_props.sv
testbench/ldq_tb.sv

//--- testbench/ldq_props.sv
`timescale 1ns/1ps
`include "ldq_defines.svh"

module ldq_props (
	input	logic					clk,
	input	logic					rst_n,
	input	ldq_pkg::ldq_vec_t		alloc_vec,
	input	logic					execute_ld_valid,
	input	ldq_pkg::ldq_tag_t		execute_ld_tag,
	input	logic					dcache_valid,
	input	ldq_pkg::ldq_tag_t		dcache_tag,
	input	logic					writeback_accept,
	input	ldq_pkg::ldq_tag_t		writeback_tag,
	input	ldq_pkg::ldq_entry_t	entries	[`LDQ_DEPTH]
);
	import ldq_pkg::*;

	ldq_vec_t	valid_vec;
	ldq_vec_t	addr_vec;
	ldq_vec_t	data_vec;

	always_comb begin
		for (int i = 0; i < `LDQ_DEPTH; i++) begin
			valid_vec[i]	= entries[i].entry_valid;
			addr_vec[i]		= entries[i].addr_valid;
			data_vec[i]		= entries[i].data_valid;
		end
	end

	// allocation only lands on free slots
	alloc_free: assert property (@(posedge clk) disable iff (!rst_n)
		(alloc_vec & valid_vec) == '0)
		else $error("allocate hit an entry that is still valid");

	exe_valid: assert property (@(posedge clk) disable iff (!rst_n)
		execute_ld_valid |-> entries[execute_ld_tag].entry_valid)
		else $error("execute targets an entry that is not valid");

	dcache_fired: assert property (@(posedge clk) disable iff (!rst_n)
		dcache_valid |-> entries[dcache_tag].fired)
		else $error("cache data for an entry that was never fired");

	data_has_addr: assert property (@(posedge clk) disable iff (!rst_n)
		(data_vec & ~addr_vec) == '0)
		else $error("data_valid set without addr_valid");

	wb_valid: assert property (@(posedge clk) disable iff (!rst_n)
		writeback_accept |-> entries[writeback_tag].entry_valid)
		else $error("writeback accepted for an entry that is not valid");

endmodule

//--- testbench/ldq_tb.sv
`timescale 1ns/1ps
`include "ldq_defines.svh"

module ldq_tb;
	import ldq_pkg::*;

	logic		clk;
	logic		rst_n;
	logic		pipe_flush;
	lane_vec_t	dispatch_valid;
	logic		dispatch_ready;
	ldq_tag_t	dispatch_resp	[`MACHINE_WIDTH];
	logic		execute_ld_valid;
	ldq_tag_t	execute_ld_tag;
	xlen_t		execute_ld_addr;
	mem_size_t	execute_ld_data_size;
	xlen_t		execute_ld_pc;
	prn_t		execute_ld_prn;
	rob_tag_t	execute_ld_rob_tag;
	logic		fire_ld_valid;
	logic		fire_ld_ready;
	xlen_t		fire_ld_addr;
	mem_size_t	fire_ld_data_size;
	ldq_tag_t	fire_ld_tag;
	logic		dcache_valid;
	ldq_tag_t	dcache_tag;
	xlen_t		dcache_data;
	logic		writeback_valid;
	logic		writeback_ready;
	xlen_t		writeback_data;
	xlen_t		writeback_pc;
	prn_t		writeback_dest_prn;
	rob_tag_t	writeback_rob_tag;
	lane_vec_t	retire_valid;

	// reference state kept from the queue rules
	ldq_tag_t	tail_m;
	int			cycles;
	xlen_t		exp_addr	[`LDQ_DEPTH];
	mem_size_t	exp_size	[`LDQ_DEPTH];
	xlen_t		exp_pc		[`LDQ_DEPTH];
	prn_t		exp_prn		[`LDQ_DEPTH];
	rob_tag_t	exp_rob		[`LDQ_DEPTH];
	xlen_t		exp_data	[`LDQ_DEPTH];

	ldq_tb_clk u_clk (.clk(clk));

	ldq u_dut (.*);

	bind ldq_entry_array ldq_props u_props (.*);

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("CHECKS FAILED");
		$fatal(1);
	endtask

	task automatic check(input logic [63:0] got, input logic [63:0] exp, input string what);
		if (got !== exp)
			abort_run($sformatf("Fail at %0t ns: %s got %0h expected %0h", $time, what, got, exp));
	endtask

	// tests take well under 400 cycles
	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= 2000)
			abort_run("run hit the cycle limit without finishing");
	end

	task automatic wait_valid(input bit on_wb, input string what);
		int n;
		n = 0;
		@(negedge clk);
		while (!(on_wb ? writeback_valid : fire_ld_valid)) begin
			n++;
			if (n > 50)
				abort_run($sformatf("%s never arrived", what));
			@(negedge clk);
		end
	endtask

	task automatic dispatch(input lane_vec_t lanes);
		ldq_tag_t exp;
		int j;
		@(posedge clk);
		dispatch_valid <= lanes;
		@(negedge clk);
		check(dispatch_ready, 1, "dispatch_ready");
		j = 0;
		for (int k = 0; k < `MACHINE_WIDTH; k++) begin
			exp = lanes[k] ? ldq_tag_t'(tail_m + j) : '0;	// j-th set lane gets tail+j
			check(dispatch_resp[k], exp, $sformatf("dispatch_resp[%0d]", k));
			if (lanes[k])
				j++;
		end
		@(posedge clk);
		dispatch_valid <= '0;
		tail_m = ldq_tag_t'(tail_m + j);
	endtask

	task automatic retire(input lane_vec_t lanes);
		@(posedge clk);
		retire_valid <= lanes;
		@(posedge clk);
		retire_valid <= '0;
	endtask

	task automatic execute(input ldq_tag_t tag);
		@(posedge clk);
		exp_addr[tag] = $urandom;
		exp_size[tag] = mem_size_t'($urandom);
		exp_pc[tag] = $urandom;
		exp_prn[tag] = prn_t'($urandom);
		exp_rob[tag] = rob_tag_t'($urandom);
		execute_ld_valid		<= 1'b1;
		execute_ld_tag			<= tag;
		execute_ld_addr			<= exp_addr[tag];
		execute_ld_data_size	<= exp_size[tag];
		execute_ld_pc			<= exp_pc[tag];
		execute_ld_prn			<= exp_prn[tag];
		execute_ld_rob_tag		<= exp_rob[tag];
		@(posedge clk);
		execute_ld_valid <= 1'b0;
	endtask

	task automatic cache_return(input ldq_tag_t tag);
		@(posedge clk);
		exp_data[tag] = $urandom;
		dcache_valid	<= 1'b1;
		dcache_tag		<= tag;
		dcache_data		<= exp_data[tag];
		@(posedge clk);
		dcache_valid <= 1'b0;
	endtask

	task automatic accept_fire;
		@(posedge clk);
		fire_ld_ready <= 1'b1;
		@(posedge clk);
		fire_ld_ready <= 1'b0;
	endtask

	task automatic accept_wb;
		@(posedge clk);
		writeback_ready <= 1'b1;
		@(posedge clk);
		writeback_ready <= 1'b0;
	endtask

	task automatic check_fire(input ldq_tag_t tag);
		check(fire_ld_valid, 1, "fire_ld_valid");
		check(fire_ld_tag, tag, "fire_ld_tag");
		check(fire_ld_addr, exp_addr[tag], "fire_ld_addr");
		check(fire_ld_data_size, exp_size[tag], "fire_ld_data_size");
	endtask

	task automatic check_wb(input ldq_tag_t tag);
		check(writeback_valid, 1, "writeback_valid");
		check(writeback_data, exp_data[tag], "writeback_data");
		check(writeback_pc, exp_pc[tag], "writeback_pc");
		check(writeback_dest_prn, exp_prn[tag], "writeback_dest_prn");
		check(writeback_rob_tag, exp_rob[tag], "writeback_rob_tag");
	endtask

	task automatic test_reset_compaction;
		@(negedge clk);
		check(dispatch_ready, 1, "dispatch_ready after reset");
		check(fire_ld_valid, 0, "fire_ld_valid after reset");
		check(writeback_valid, 0, "writeback_valid after reset");
		dispatch(4'b1010);
	endtask

	task automatic test_capacity;
		dispatch(4'b0111);
		@(negedge clk);
		check(dispatch_ready, 0, "dispatch_ready when full");	// five in use, three free
		retire(4'b0101);
		@(negedge clk);
		check(dispatch_ready, 1, "dispatch_ready after retire");	// back to five free
	endtask

	task automatic test_lifecycle;
		execute(3'd2);
		wait_valid(1'b0, "fire request");
		check_fire(3'd2);
		accept_fire();
		@(negedge clk);
		check(fire_ld_valid, 0, "fire_ld_valid after accept");
		cache_return(3'd2);
		wait_valid(1'b1, "writeback");
		check_wb(3'd2);
		accept_wb();
		@(negedge clk);
		check(writeback_valid, 0, "writeback_valid after accept");
		retire(4'b0001);
	endtask

	task automatic test_backpressure;
		execute(3'd3);
		wait_valid(1'b0, "fire request");
		repeat (3) begin
			check_fire(3'd3);	// held while ready is low
			@(negedge clk);
		end
		accept_fire();
		cache_return(3'd3);
		wait_valid(1'b1, "writeback");
		repeat (3) begin
			check_wb(3'd3);
			@(negedge clk);
		end
		accept_wb();
		retire(4'b0001);
	endtask

	task automatic test_age_wrap;
		retire(4'b0001);
		dispatch(4'b1111);	// tags 5 6 7 0
		retire(4'b0011);	// head now at 7
		execute(3'd0);
		execute(3'd7);
		@(posedge clk);
		@(negedge clk);
		check_fire(3'd7);
		accept_fire();
		@(negedge clk);
		check_fire(3'd0);
		accept_fire();
		@(negedge clk);
		check(fire_ld_valid, 0, "fire_ld_valid after both fired");
		cache_return(3'd0);
		cache_return(3'd7);
		@(negedge clk);
		check_wb(3'd7);
		accept_wb();
		@(negedge clk);
		check_wb(3'd0);
		accept_wb();
		@(negedge clk);
		check(writeback_valid, 0, "writeback_valid after both written");
		retire(4'b0011);
	endtask

	task automatic test_flush;
		dispatch(4'b0011);
		execute(3'd1);
		execute(3'd2);
		wait_valid(1'b0, "fire request");
		check_fire(3'd1);
		accept_fire();
		cache_return(3'd1);
		@(negedge clk);
		check_wb(3'd1);
		check_fire(3'd2);
		@(posedge clk);
		pipe_flush <= 1'b1;
		@(posedge clk);
		pipe_flush <= 1'b0;
		tail_m = '0;
		@(negedge clk);
		check(fire_ld_valid, 0, "fire_ld_valid after flush");
		check(writeback_valid, 0, "writeback_valid after flush");
		check(dispatch_ready, 1, "dispatch_ready after flush");
		dispatch(4'b0001);
	endtask

	initial begin
		void'($urandom(32'ha1e2_2e95));
		rst_n = 1'b0;
		pipe_flush = 1'b0;
		dispatch_valid = '0;
		execute_ld_valid = 1'b0;
		execute_ld_tag = '0;
		execute_ld_addr = '0;
		execute_ld_data_size = '0;
		execute_ld_pc = '0;
		execute_ld_prn = '0;
		execute_ld_rob_tag = '0;
		fire_ld_ready = 1'b0;
		dcache_valid = 1'b0;
		dcache_tag = '0;
		dcache_data = '0;
		writeback_ready = 1'b0;
		retire_valid = '0;
		tail_m = '0;
		cycles = 0;
		repeat (2) @(posedge clk);
		rst_n <= 1'b1;
		test_reset_compaction();
		test_capacity();
		test_lifecycle();
		test_backpressure();
		test_age_wrap();
		test_flush();
		$display("ALL CHECKS PASSED");
		$finish;
	end

endmodule

//--- testbench/ldq_tb_clk.sv
`timescale 1ns/1ps

module ldq_tb_clk (
	output	logic	clk
);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;	// 100 ns period
	end

endmodule

//--- verilog/ldq.sv
`timescale 1ns/1ps
`include "ldq_defines.svh"

module ldq (
	input	logic					clk,
	input	logic					rst_n,
	input	logic					pipe_flush,

	input	ldq_pkg::lane_vec_t		dispatch_valid,
	output	logic					dispatch_ready,
	output	ldq_pkg::ldq_tag_t		dispatch_resp	[`MACHINE_WIDTH],

	input	logic					execute_ld_valid,
	input	ldq_pkg::ldq_tag_t		execute_ld_tag,
	input	ldq_pkg::xlen_t			execute_ld_addr,
	input	ldq_pkg::mem_size_t		execute_ld_data_size,
	input	ldq_pkg::xlen_t			execute_ld_pc,
	input	ldq_pkg::prn_t			execute_ld_prn,
	input	ldq_pkg::rob_tag_t		execute_ld_rob_tag,

	output	logic					fire_ld_valid,
	input	logic					fire_ld_ready,
	output	ldq_pkg::xlen_t			fire_ld_addr,
	output	ldq_pkg::mem_size_t		fire_ld_data_size,
	output	ldq_pkg::ldq_tag_t		fire_ld_tag,

	input	logic					dcache_valid,
	input	ldq_pkg::ldq_tag_t		dcache_tag,
	input	ldq_pkg::xlen_t			dcache_data,

	output	logic					writeback_valid,
	input	logic					writeback_ready,
	output	ldq_pkg::xlen_t			writeback_data,
	output	ldq_pkg::xlen_t			writeback_pc,
	output	ldq_pkg::prn_t			writeback_dest_prn,
	output	ldq_pkg::rob_tag_t		writeback_rob_tag,

	input	ldq_pkg::lane_vec_t		retire_valid
);
	import ldq_pkg::*;

	ldq_tag_t	head_ptr;
	ldq_vec_t	alloc_vec;
	ldq_vec_t	free_vec;
	ldq_entry_t	entries	[`LDQ_DEPTH];
	logic		fire_accept;
	logic		writeback_accept;
	ldq_tag_t	writeback_tag;

	ldq_alloc u_alloc (
		.clk			(clk),
		.rst_n			(rst_n),
		.pipe_flush		(pipe_flush),
		.dispatch_valid	(dispatch_valid),
		.retire_valid	(retire_valid),
		.dispatch_ready	(dispatch_ready),
		.dispatch_resp	(dispatch_resp),
		.head_ptr		(head_ptr),
		.alloc_vec		(alloc_vec),
		.free_vec		(free_vec)
	);

	ldq_entry_array u_entry_array (
		.clk					(clk),
		.rst_n					(rst_n),
		.pipe_flush				(pipe_flush),
		.alloc_vec				(alloc_vec),
		.free_vec				(free_vec),
		.execute_ld_valid		(execute_ld_valid),
		.execute_ld_tag			(execute_ld_tag),
		.execute_ld_addr		(execute_ld_addr),
		.execute_ld_data_size	(execute_ld_data_size),
		.execute_ld_pc			(execute_ld_pc),
		.execute_ld_prn			(execute_ld_prn),
		.execute_ld_rob_tag		(execute_ld_rob_tag),
		.fire_accept			(fire_accept),
		.fire_tag				(fire_ld_tag),
		.dcache_valid			(dcache_valid),
		.dcache_tag				(dcache_tag),
		.dcache_data			(dcache_data),
		.writeback_accept		(writeback_accept),
		.writeback_tag			(writeback_tag),
		.entries				(entries)
	);

	ldq_fire u_fire (
		.clk				(clk),
		.rst_n				(rst_n),
		.pipe_flush			(pipe_flush),
		.entries			(entries),
		.head_ptr			(head_ptr),
		.fire_ld_ready		(fire_ld_ready),
		.fire_ld_valid		(fire_ld_valid),
		.fire_ld_addr		(fire_ld_addr),
		.fire_ld_data_size	(fire_ld_data_size),
		.fire_ld_tag		(fire_ld_tag),
		.fire_accept		(fire_accept)
	);

	ldq_writeback u_writeback (
		.entries			(entries),
		.head_ptr			(head_ptr),
		.writeback_ready	(writeback_ready),
		.writeback_valid	(writeback_valid),
		.writeback_data		(writeback_data),
		.writeback_pc		(writeback_pc),
		.writeback_dest_prn	(writeback_dest_prn),
		.writeback_rob_tag	(writeback_rob_tag),
		.writeback_tag		(writeback_tag),
		.writeback_accept	(writeback_accept)
	);

endmodule

//--- verilog/ldq_age_pick.sv
`timescale 1ns/1ps
`include "ldq_defines.svh"

module ldq_age_pick (
	input	ldq_pkg::ldq_vec_t	request,
	input	ldq_pkg::ldq_tag_t	head_ptr,
	output	logic				any,
	output	ldq_pkg::ldq_tag_t	pick
);
	import ldq_pkg::*;

	ldq_vec_t					age_mask;
	logic	[2*`LDQ_DEPTH-1:0]	req_double;

	// lower half only keeps entries at or above the head
	always_comb begin
		for (int i = 0; i < `LDQ_DEPTH; i++) begin
			age_mask[i] = ldq_tag_t'(i) >= head_ptr;
		end
	end

	assign req_double	= {request, request & age_mask};
	assign any			= |request;

	// lowest set bit of the doubled vector, folded back onto the ring
	always_comb begin
		pick = '0;
		for (int i = 2*`LDQ_DEPTH-1; i >= 0; i--) begin
			if (req_double[i])
				pick = ldq_tag_t'(i);
		end
	end

endmodule

//--- verilog/ldq_alloc.sv
`timescale 1ns/1ps
`include "ldq_defines.svh"

module ldq_alloc (
	input	logic					clk,
	input	logic					rst_n,
	input	logic					pipe_flush,
	input	ldq_pkg::lane_vec_t		dispatch_valid,
	input	ldq_pkg::lane_vec_t		retire_valid,
	output	logic					dispatch_ready,
	output	ldq_pkg::ldq_tag_t		dispatch_resp	[`MACHINE_WIDTH],
	output	ldq_pkg::ldq_tag_t		head_ptr,
	output	ldq_pkg::ldq_vec_t		alloc_vec,
	output	ldq_pkg::ldq_vec_t		free_vec
);
	import ldq_pkg::*;

	ldq_tag_t				tail_ptr;
	logic	[`LDQ_WIDTH:0]	occupancy;		// 0 .. LDQ_DEPTH
	logic	[`LDQ_WIDTH:0]	dispatch_cnt;
	logic	[`LDQ_WIDTH:0]	retire_cnt;
	lane_vec_t				lane_take;

	// only accept when a full group fits
	assign dispatch_ready	= occupancy <= (`LDQ_DEPTH - `MACHINE_WIDTH);
	assign lane_take		= dispatch_valid & {`MACHINE_WIDTH{dispatch_ready}};

	// the j-th taken lane gets tail+j
	always_comb begin
		dispatch_cnt = '0;
		alloc_vec = '0;
		for (int k = 0; k < `MACHINE_WIDTH; k++) begin
			dispatch_resp[k] = '0;
			if (lane_take[k]) begin
				dispatch_resp[k] = tail_ptr + dispatch_cnt[`LDQ_WIDTH-1:0];
				alloc_vec[dispatch_resp[k]] = 1'b1;
				dispatch_cnt = dispatch_cnt + 1'b1;
			end
		end
	end

	// retire frees in order from the head
	always_comb begin
		retire_cnt = '0;
		for (int k = 0; k < `MACHINE_WIDTH; k++) begin
			retire_cnt = retire_cnt + retire_valid[k];
		end
		free_vec = '0;
		for (int k = 0; k < `MACHINE_WIDTH; k++) begin
			if (k < retire_cnt) begin
				free_vec[head_ptr + ldq_tag_t'(k)] = 1'b1;
			end
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			head_ptr	<= '0;
			tail_ptr	<= '0;
			occupancy	<= '0;
		end else if (pipe_flush) begin
			head_ptr	<= '0;
			tail_ptr	<= '0;
			occupancy	<= '0;
		end else begin
			head_ptr	<= head_ptr + retire_cnt[`LDQ_WIDTH-1:0];	// wraps with the ring
			tail_ptr	<= tail_ptr + dispatch_cnt[`LDQ_WIDTH-1:0];
			occupancy	<= occupancy + dispatch_cnt - retire_cnt;
		end
	end

endmodule

//--- verilog/ldq_defines.svh
`ifndef LDQ_DEFINES_SVH
`define LDQ_DEFINES_SVH

// queue geometry
`define LDQ_DEPTH		8
`define LDQ_WIDTH		3	// log2 of LDQ_DEPTH

// dispatch and retire lanes per cycle
`define MACHINE_WIDTH	4

// datapath
`define XLEN			32
`define PRF_WIDTH		6

// rob index bits, tags add one wrap bit on top
`define ROB_WIDTH		5

`endif

//--- verilog/ldq_entry_array.sv
`timescale 1ns/1ps
`include "ldq_defines.svh"

module ldq_entry_array (
	input	logic					clk,
	input	logic					rst_n,
	input	logic					pipe_flush,
	input	ldq_pkg::ldq_vec_t		alloc_vec,
	input	ldq_pkg::ldq_vec_t		free_vec,

	input	logic					execute_ld_valid,
	input	ldq_pkg::ldq_tag_t		execute_ld_tag,
	input	ldq_pkg::xlen_t			execute_ld_addr,
	input	ldq_pkg::mem_size_t		execute_ld_data_size,
	input	ldq_pkg::xlen_t			execute_ld_pc,
	input	ldq_pkg::prn_t			execute_ld_prn,
	input	ldq_pkg::rob_tag_t		execute_ld_rob_tag,

	input	logic					fire_accept,
	input	ldq_pkg::ldq_tag_t		fire_tag,

	input	logic					dcache_valid,
	input	ldq_pkg::ldq_tag_t		dcache_tag,
	input	ldq_pkg::xlen_t			dcache_data,

	input	logic					writeback_accept,
	input	ldq_pkg::ldq_tag_t		writeback_tag,

	output	ldq_pkg::ldq_entry_t	entries	[`LDQ_DEPTH]
);
	import ldq_pkg::*;

	genvar i;
	generate
		for (i = 0; i < `LDQ_DEPTH; i++) begin : g_entry
			logic exe_hit;
			logic fire_hit;
			logic dc_hit;
			logic wb_hit;

			assign exe_hit	= execute_ld_valid && execute_ld_tag == ldq_tag_t'(i);
			assign fire_hit	= fire_accept && fire_tag == ldq_tag_t'(i);
			assign dc_hit	= dcache_valid && dcache_tag == ldq_tag_t'(i);
			assign wb_hit	= writeback_accept && writeback_tag == ldq_tag_t'(i);

			always_ff @(posedge clk or negedge rst_n) begin
				if (!rst_n) begin
					entries[i].entry_valid	<= 1'b0;
					entries[i].addr_valid	<= 1'b0;
					entries[i].fired		<= 1'b0;
					entries[i].data_valid	<= 1'b0;
					entries[i].writebacked	<= 1'b0;
				end else if (pipe_flush || free_vec[i]) begin
					entries[i].entry_valid	<= 1'b0;
					entries[i].addr_valid	<= 1'b0;
					entries[i].fired		<= 1'b0;
					entries[i].data_valid	<= 1'b0;
					entries[i].writebacked	<= 1'b0;
				end else begin
					if (alloc_vec[i])
						entries[i].entry_valid <= 1'b1;
					// address and tracking info from the agu
					if (exe_hit) begin
						entries[i].addr_valid	<= 1'b1;
						entries[i].addr			<= execute_ld_addr;
						entries[i].data_size	<= execute_ld_data_size;
						entries[i].pc			<= execute_ld_pc;
						entries[i].dest_prn		<= execute_ld_prn;
						entries[i].rob_tag		<= execute_ld_rob_tag;
					end
					if (fire_hit)
						entries[i].fired <= 1'b1;
					if (dc_hit) begin
						entries[i].data_valid	<= 1'b1;
						entries[i].data			<= dcache_data;
					end
					if (wb_hit)
						entries[i].writebacked <= 1'b1;	// never sent again
				end
			end
		end
	endgenerate

endmodule

//--- verilog/ldq_fire.sv
`timescale 1ns/1ps
`include "ldq_defines.svh"

module ldq_fire (
	input	logic					clk,
	input	logic					rst_n,
	input	logic					pipe_flush,
	input	ldq_pkg::ldq_entry_t	entries	[`LDQ_DEPTH],
	input	ldq_pkg::ldq_tag_t		head_ptr,
	input	logic					fire_ld_ready,
	output	logic					fire_ld_valid,
	output	ldq_pkg::xlen_t			fire_ld_addr,
	output	ldq_pkg::mem_size_t		fire_ld_data_size,
	output	ldq_pkg::ldq_tag_t		fire_ld_tag,
	output	logic					fire_accept
);
	import ldq_pkg::*;

	ldq_vec_t	wakeup;
	logic		wakeup_any;
	ldq_tag_t	fire_idx;

	assign fire_accept = fire_ld_valid && fire_ld_ready;

	// address known, not yet sent, no data; the one going out now is skipped
	always_comb begin
		for (int i = 0; i < `LDQ_DEPTH; i++) begin
			wakeup[i] = entries[i].entry_valid && entries[i].addr_valid &&
				!entries[i].fired && !entries[i].data_valid &&
				!(fire_accept && fire_ld_tag == ldq_tag_t'(i));
		end
	end

	ldq_age_pick u_pick (
		.request	(wakeup),
		.head_ptr	(head_ptr),
		.any		(wakeup_any),
		.pick		(fire_idx)
	);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			fire_ld_valid <= 1'b0;
		else if (pipe_flush)
			fire_ld_valid <= 1'b0;
		else
			fire_ld_valid <= wakeup_any;
	end

	always_ff @(posedge clk) begin
		fire_ld_addr		<= entries[fire_idx].addr;
		fire_ld_data_size	<= entries[fire_idx].data_size;
		fire_ld_tag			<= fire_idx;
	end

endmodule

//--- verilog/ldq_pkg.sv
`include "ldq_defines.svh"

package ldq_pkg;

	typedef logic [`LDQ_WIDTH-1:0]		ldq_tag_t;
	typedef logic [`LDQ_DEPTH-1:0]		ldq_vec_t;	// one bit per entry
	typedef logic [`MACHINE_WIDTH-1:0]	lane_vec_t;	// one bit per lane

	typedef logic [`XLEN-1:0]			xlen_t;
	typedef logic [2:0]					mem_size_t;
	typedef logic [`PRF_WIDTH-1:0]		prn_t;
	typedef logic [`ROB_WIDTH:0]		rob_tag_t;

	// per entry state
	typedef struct packed {
		logic		entry_valid;
		logic		addr_valid;
		logic		fired;		// request taken by the dcache
		logic		data_valid;
		logic		writebacked;
		xlen_t		addr;
		mem_size_t	data_size;
		xlen_t		pc;
		prn_t		dest_prn;
		rob_tag_t	rob_tag;
		xlen_t		data;
	} ldq_entry_t;

endpackage

//--- verilog/ldq_writeback.sv
`timescale 1ns/1ps
`include "ldq_defines.svh"

module ldq_writeback (
	input	ldq_pkg::ldq_entry_t	entries	[`LDQ_DEPTH],
	input	ldq_pkg::ldq_tag_t		head_ptr,
	input	logic					writeback_ready,
	output	logic					writeback_valid,
	output	ldq_pkg::xlen_t			writeback_data,
	output	ldq_pkg::xlen_t			writeback_pc,
	output	ldq_pkg::prn_t			writeback_dest_prn,
	output	ldq_pkg::rob_tag_t		writeback_rob_tag,
	output	ldq_pkg::ldq_tag_t		writeback_tag,
	output	logic					writeback_accept
);
	import ldq_pkg::*;

	ldq_vec_t	wb_req;

	// data is back but result not yet broadcast
	always_comb begin
		for (int i = 0; i < `LDQ_DEPTH; i++) begin
			wb_req[i] = entries[i].entry_valid && entries[i].data_valid &&
				!entries[i].writebacked;
		end
	end

	ldq_age_pick u_pick (
		.request	(wb_req),
		.head_ptr	(head_ptr),
		.any		(writeback_valid),
		.pick		(writeback_tag)
	);

	assign writeback_data		= entries[writeback_tag].data;
	assign writeback_pc			= entries[writeback_tag].pc;
	assign writeback_dest_prn	= entries[writeback_tag].dest_prn;
	assign writeback_rob_tag	= entries[writeback_tag].rob_tag;
	assign writeback_accept		= writeback_valid && writeback_ready;

endmodule
